// ==== source/cpu_params.svh ====
// memory depths are word-address widths; both memories index with byte address bits [AW+1:2] and wrap above them
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// instruction memory holds 2**CPU_IMEM_AW words
`define CPU_IMEM_AW 8

// data memory holds 2**CPU_DMEM_AW words
`define CPU_DMEM_AW 8

// fetch restarts here after reset and whenever run_i is low
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== source/isa_pkg.sv ====
// encodings cover only the MIPS subset this core executes; any other opcode or funct retires nothing
package isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] jtarget_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_ORI   = 6'h0d,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    function automatic opcode_e op_of(input instr_t instr);
        return opcode_e'(instr[31:26]);  // values outside the enum fall to the decoder default
    endfunction

    function automatic funct_e funct_of(input instr_t instr);
        return funct_e'(instr[5:0]);
    endfunction

endpackage

// ==== source/pipe_pkg.sv ====
// ALU op and forwarding select codes are internal to the core and carry no ISA meaning
package pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam reg_idx_t REG_ZERO = '0;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL
    } alu_op_e;

    // operand source in execute, nearest producer first
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

// ==== source/pipe_if.sv ====
// both bundles are driven from a register in the upstream stage; valid low marks a bubble
`timescale 1ns/1ps

interface iss_ex_if import pipe_pkg::*;;
    logic     valid;
    logic     reg_wr;
    logic     mem_to_reg;
    logic     mem_wr;
    alu_op_e  alu_op;
    reg_idx_t rs;          // source of operand_a, zero when operand_a is not a register
    reg_idx_t rt;          // source of operand_b or of store_data, zero when neither
    reg_idx_t rd;
    word_t    operand_a;
    word_t    operand_b;
    word_t    store_data;

    modport issue (output valid, reg_wr, mem_to_reg, mem_wr, alu_op, rs, rt, rd,
                   operand_a, operand_b, store_data);
    modport exec  (input valid, reg_wr, mem_to_reg, mem_wr, alu_op, rs, rt, rd,
                   operand_a, operand_b, store_data);
endinterface

interface ex_mem_if import pipe_pkg::*;;
    logic     valid;
    logic     reg_wr;
    logic     mem_to_reg;
    logic     mem_wr;
    reg_idx_t rd;
    word_t    alu_res;
    word_t    store_data;

    modport exec (output valid, reg_wr, mem_to_reg, mem_wr, rd, alu_res, store_data);
    modport mem  (input valid, reg_wr, mem_to_reg, mem_wr, rd, alu_res, store_data);
endinterface

// ==== source/fetch_stage.sv ====
// load the instruction memory only while run_i is low; its write address is a byte address
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic   clk_i,
    input  logic   arst_n_i,
    input  logic   run_i,
    input  logic   imem_wr_en_i,
    input  word_t  imem_wr_addr_i,
    input  instr_t imem_wr_data_i,
    input  logic   stall_i,
    input  logic   redirect_i,
    input  word_t  redirect_pc_i,
    output instr_t instr_o,
    output word_t  pc_plus4_o,
    output logic   valid_o
);

    instr_t imem_q [2**`CPU_IMEM_AW];
    word_t  pc_q;
    word_t  pc_next_seq;
    logic   advance;

    assign pc_next_seq = pc_q + 32'd4;
    assign advance     = run_i && !redirect_i && !stall_i;

    always_ff @(posedge clk_i) begin
        if (imem_wr_en_i) begin
            imem_q[imem_wr_addr_i[`CPU_IMEM_AW+1:2]] <= imem_wr_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= `CPU_RESET_PC;
            valid_o <= 1'b0;
        end else if (!run_i) begin
            pc_q    <= `CPU_RESET_PC;  // every run starts over from the reset vector
            valid_o <= 1'b0;
        end else if (redirect_i) begin
            pc_q    <= redirect_pc_i;
            valid_o <= 1'b0;           // the word fetched behind a branch or jump is dropped
        end else if (!stall_i) begin
            pc_q    <= pc_next_seq;
            valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            instr_o    <= imem_q[pc_q[`CPU_IMEM_AW+1:2]];
            pc_plus4_o <= pc_next_seq;
        end
    end

endmodule

// ==== source/issue_stage.sv ====
// branches and jumps resolve here with no delay slot; a BEQ waits until its operands reach writeback
`timescale 1ns/1ps

module issue_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  instr_t   instr_i,
    input  word_t    pc_plus4_i,
    input  logic     valid_i,
    input  logic     wb_en_i,
    input  reg_idx_t wb_rd_i,
    input  word_t    wb_data_i,
    output logic     stall_o,
    output logic     redirect_o,
    output word_t    redirect_pc_o,
    iss_ex_if.issue  iss_ex
);

    word_t    rf_q [32];
    reg_idx_t rs, rt, rd_field, src_a, src_b, dst;
    shamt_t   shamt;
    imm16_t   imm;
    jtarget_t jtarget;
    word_t    sext_imm, rs_data, rt_data, op_a, op_b;
    logic     reg_wr, mem_to_reg, mem_wr, is_beq, is_j;
    alu_op_e  alu_op;
    logic     mem_reg_wr_q;  // shadow of the memory stage, which always follows execute
    reg_idx_t mem_rd_q;
    logic     load_use, beq_wait, go;

    function automatic logic hit(input logic wr, input reg_idx_t dst_idx, input reg_idx_t src);
        return wr && dst_idx != REG_ZERO && dst_idx == src;
    endfunction

    assign rs       = instr_i[25:21];
    assign rt       = instr_i[20:16];
    assign rd_field = instr_i[15:11];
    assign shamt    = instr_i[10:6];
    assign imm      = instr_i[15:0];
    assign jtarget  = instr_i[25:0];
    assign sext_imm = {{16{imm[15]}}, imm};

    // register 0 reads zero, a same-cycle writeback passes straight through
    assign rs_data = (rs == REG_ZERO) ? '0 : (wb_en_i && wb_rd_i == rs) ? wb_data_i : rf_q[rs];
    assign rt_data = (rt == REG_ZERO) ? '0 : (wb_en_i && wb_rd_i == rt) ? wb_data_i : rf_q[rt];

    always_comb begin
        {reg_wr, mem_to_reg, mem_wr, is_beq, is_j} = '0;
        alu_op = ALU_ADD;
        dst    = rt;
        src_a  = rs;
        src_b  = REG_ZERO;
        op_a   = rs_data;
        op_b   = sext_imm;
        case (op_of(instr_i))
            OP_RTYPE: begin
                reg_wr = 1'b1;
                dst    = rd_field;
                src_b  = rt;
                op_b   = rt_data;
                case (funct_of(instr_i))
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL: begin
                        alu_op = ALU_SLL;
                        src_a  = rt;  // shifts take rt as the data operand
                        op_a   = rt_data;
                        src_b  = REG_ZERO;
                        op_b   = {27'b0, shamt};
                    end
                    default: reg_wr = 1'b0;
                endcase
            end
            OP_ADDIU: reg_wr = 1'b1;
            OP_ORI: begin
                reg_wr = 1'b1;
                alu_op = ALU_OR;
                op_b   = {16'b0, imm};
            end
            OP_LW: {reg_wr, mem_to_reg} = 2'b11;
            OP_SW: begin
                mem_wr = 1'b1;
                src_b  = rt;  // store data, the address still uses the immediate
            end
            OP_BEQ: begin
                is_beq = 1'b1;
                src_b  = rt;
            end
            OP_J: begin
                is_j  = 1'b1;
                src_a = REG_ZERO;
            end
            default: src_a = REG_ZERO;
        endcase
    end

    assign load_use = iss_ex.mem_to_reg &&
                      (hit(iss_ex.reg_wr, iss_ex.rd, src_a) || hit(iss_ex.reg_wr, iss_ex.rd, src_b));
    assign beq_wait = is_beq &&
                      (hit(iss_ex.reg_wr, iss_ex.rd, rs) || hit(iss_ex.reg_wr, iss_ex.rd, rt) ||
                       hit(mem_reg_wr_q, mem_rd_q, rs) || hit(mem_reg_wr_q, mem_rd_q, rt));
    assign stall_o  = valid_i && (load_use || beq_wait);
    assign go       = valid_i && !stall_o;

    assign redirect_o    = go && (is_j || (is_beq && rs_data == rt_data));
    assign redirect_pc_o = is_j ? {pc_plus4_i[31:28], jtarget, 2'b00}
                                : pc_plus4_i + {sext_imm[29:0], 2'b00};

    always_ff @(posedge clk_i) begin
        if (wb_en_i) begin
            rf_q[wb_rd_i] <= wb_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            {iss_ex.valid, iss_ex.reg_wr, iss_ex.mem_to_reg, iss_ex.mem_wr} <= '0;
            mem_reg_wr_q <= 1'b0;
        end else begin
            iss_ex.valid      <= go;  // a stall leaves a bubble behind it
            iss_ex.reg_wr     <= go && reg_wr;
            iss_ex.mem_to_reg <= go && mem_to_reg;
            iss_ex.mem_wr     <= go && mem_wr;
            mem_reg_wr_q      <= iss_ex.reg_wr;
        end
    end

    always_ff @(posedge clk_i) begin
        iss_ex.alu_op     <= alu_op;
        iss_ex.rs         <= src_a;
        iss_ex.rt         <= src_b;
        iss_ex.rd         <= dst;
        iss_ex.operand_a  <= op_a;
        iss_ex.operand_b  <= op_b;
        iss_ex.store_data <= rt_data;
        mem_rd_q          <= iss_ex.rd;
    end

endmodule

// ==== source/exec_stage.sv ====
// the memory-stage result forwards as ALU data only; a load result arrives through writeback
`timescale 1ns/1ps

module exec_stage import pipe_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    iss_ex_if.exec   iss_ex,
    input  logic     wb_en_i,
    input  reg_idx_t wb_rd_i,
    input  word_t    wb_data_i,
    ex_mem_if.exec   ex_mem
);

    fwd_sel_e sel_a, sel_b;
    logic     mem_fwd_ok;
    word_t    op_a, op_b, store_val, alu_res;

    function automatic fwd_sel_e pick_src(input reg_idx_t src, input logic mem_ok,
                                          input reg_idx_t mem_rd, input logic wb_ok,
                                          input reg_idx_t wb_rd);
        if (src == REG_ZERO) return FWD_RF;
        if (mem_ok && mem_rd == src) return FWD_MEM;
        if (wb_ok && wb_rd == src) return FWD_WB;
        return FWD_RF;
    endfunction

    function automatic word_t fwd_val(input fwd_sel_e sel, input word_t rf_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign mem_fwd_ok = ex_mem.valid && ex_mem.reg_wr;
    assign sel_a = pick_src(iss_ex.rs, mem_fwd_ok, ex_mem.rd, wb_en_i, wb_rd_i);
    assign sel_b = pick_src(iss_ex.rt, mem_fwd_ok, ex_mem.rd, wb_en_i, wb_rd_i);

    assign op_a      = fwd_val(sel_a, iss_ex.operand_a, ex_mem.alu_res, wb_data_i);
    assign store_val = fwd_val(sel_b, iss_ex.store_data, ex_mem.alu_res, wb_data_i);
    // on a store rt feeds the data, operand_b keeps the offset
    assign op_b = iss_ex.mem_wr ? iss_ex.operand_b
                                : fwd_val(sel_b, iss_ex.operand_b, ex_mem.alu_res, wb_data_i);

    always_comb begin
        case (iss_ex.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLL: alu_res = op_a << op_b[4:0];
            default: alu_res = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            {ex_mem.valid, ex_mem.reg_wr, ex_mem.mem_to_reg, ex_mem.mem_wr} <= '0;
        end else begin
            ex_mem.valid      <= iss_ex.valid;
            ex_mem.reg_wr     <= iss_ex.reg_wr;
            ex_mem.mem_to_reg <= iss_ex.mem_to_reg;
            ex_mem.mem_wr     <= iss_ex.mem_wr;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_mem.rd         <= iss_ex.rd;
        ex_mem.alu_res    <= alu_res;
        ex_mem.store_data <= store_val;
    end

endmodule

// ==== source/mem_wb_stage.sv ====
// data memory has no byte strobes; each store writes a whole word and the low address bits are ignored
`timescale 1ns/1ps
`include "cpu_params.svh"

module mem_wb_stage import pipe_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    ex_mem_if.mem    ex_mem,
    output logic     wb_en_o,
    output reg_idx_t wb_rd_o,
    output word_t    wb_data_o,
    output logic     store_valid_o,
    output word_t    store_addr_o,
    output word_t    store_data_o
);

    word_t                  dmem_q [2**`CPU_DMEM_AW];
    logic [`CPU_DMEM_AW-1:0] dmem_addr;
    word_t                  load_data;
    logic                   store_commit;
    logic                   wb_wr_q;
    logic                   mem_to_reg_q;
    reg_idx_t               rd_q;
    word_t                  alu_q, load_q;

    assign dmem_addr    = ex_mem.alu_res[`CPU_DMEM_AW+1:2];
    assign load_data    = dmem_q[dmem_addr];  // asynchronous read in the memory stage
    assign store_commit = ex_mem.valid && ex_mem.mem_wr;

    always_ff @(posedge clk_i) begin
        if (store_commit) begin
            dmem_q[dmem_addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_wr_q       <= 1'b0;
            store_valid_o <= 1'b0;
        end else begin
            wb_wr_q       <= ex_mem.valid && ex_mem.reg_wr && ex_mem.rd != REG_ZERO;
            store_valid_o <= store_commit;  // reported alongside writeback of the same slot
        end
    end

    always_ff @(posedge clk_i) begin
        mem_to_reg_q <= ex_mem.mem_to_reg;
        rd_q         <= ex_mem.rd;
        alu_q        <= ex_mem.alu_res;
        load_q       <= load_data;
        store_addr_o <= ex_mem.alu_res;
        store_data_o <= ex_mem.store_data;
    end

    assign wb_en_o   = wb_wr_q;
    assign wb_rd_o   = rd_q;
    assign wb_data_o = mem_to_reg_q ? load_q : alu_q;

endmodule

// ==== source/cpu_top.sv ====
// load the program with run_i low, then raise it; retires and stores appear in program order
`timescale 1ns/1ps

module cpu_top import isa_pkg::*, pipe_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        run_i,
    input  logic        imem_wr_en_i,
    input  logic [31:0] imem_wr_addr_i,
    input  logic [31:0] imem_wr_data_i,
    output logic        retire_valid_o,
    output logic [4:0]  retire_rd_o,
    output logic [31:0] retire_data_o,
    output logic        store_valid_o,
    output logic [31:0] store_addr_o,
    output logic [31:0] store_data_o
);

    instr_t   fi_instr;
    word_t    fi_pc_plus4;
    logic     fi_valid;
    logic     stall, redirect;
    word_t    redirect_pc;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    iss_ex_if iss_ex_i ();
    ex_mem_if ex_mem_i ();

    fetch_stage fetch_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .run_i          (run_i),
        .imem_wr_en_i   (imem_wr_en_i),
        .imem_wr_addr_i (imem_wr_addr_i),
        .imem_wr_data_i (imem_wr_data_i),
        .stall_i        (stall),
        .redirect_i     (redirect),
        .redirect_pc_i  (redirect_pc),
        .instr_o        (fi_instr),
        .pc_plus4_o     (fi_pc_plus4),
        .valid_o        (fi_valid)
    );

    issue_stage issue_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_i       (fi_instr),
        .pc_plus4_i    (fi_pc_plus4),
        .valid_i       (fi_valid),
        .wb_en_i       (wb_en),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .stall_o       (stall),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .iss_ex        (iss_ex_i)
    );

    exec_stage exec_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .iss_ex    (iss_ex_i),
        .wb_en_i   (wb_en),
        .wb_rd_i   (wb_rd),
        .wb_data_i (wb_data),
        .ex_mem    (ex_mem_i)
    );

    mem_wb_stage mem_wb_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .ex_mem        (ex_mem_i),
        .wb_en_o       (wb_en),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .store_valid_o (store_valid_o),
        .store_addr_o  (store_addr_o),
        .store_data_o  (store_data_o)
    );

    assign retire_valid_o = wb_en;  // register 0 writes never show up here
    assign retire_rd_o    = wb_rd;
    assign retire_data_o  = wb_data;

endmodule

// ==== dv/cpu_chk.sv ====
// bound into issue_stage; properties sample on the rising clock and most are off while reset is low
`timescale 1ns/1ps

module cpu_chk (
    input logic        clk_i,
    input logic        arst_n_i,
    input logic        valid_i,
    input logic [31:0] instr_i,
    input logic        stall_i,
    input logic        redirect_i,
    input logic        wb_en_i,
    input logic [4:0]  wb_rd_i
);

    int fails = 0;

    // a stall keeps the same instruction waiting in issue
    stall_holds: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_i |=> valid_i && $stable(instr_i))
        else begin
            $error("issue lost or changed its instruction during a stall");
            fails++;
        end

    // the word fetched behind a taken branch or jump never reaches issue
    redirect_flushes: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        redirect_i |=> !valid_i)
        else begin
            $error("instruction behind a redirect reached issue");
            fails++;
        end

    // register 0 is never written, so it keeps reading as zero
    no_zero_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_en_i |-> wb_rd_i != 5'd0)
        else begin
            $error("writeback to register 0");
            fails++;
        end

    valid_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !valid_i)
        else begin
            $error("issue valid high during reset");
            fails++;
        end

endmodule

bind issue_stage cpu_chk chk_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .valid_i    (valid_i),
    .instr_i    (instr_i),
    .stall_i    (stall_o),
    .redirect_i (redirect_o),
    .wb_en_i    (wb_en_i),
    .wb_rd_i    (wb_rd_i)
);

// ==== dv/cpu_monitor.sv ====
// captures the program from the load port; registers and data memory of the model start at zero
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_monitor import isa_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        run_i,
    input  logic        imem_wr_en_i,
    input  logic [31:0] imem_wr_addr_i,
    input  logic [31:0] imem_wr_data_i,
    input  logic        retire_valid_i,
    input  logic [4:0]  retire_rd_i,
    input  logic [31:0] retire_data_i,
    input  logic        store_valid_i,
    input  logic [31:0] store_addr_i,
    input  logic [31:0] store_data_i,
    output logic        done_o,
    output int          steps_o,
    output int          errors_o
);

    logic [31:0] prog_mem [2**`CPU_IMEM_AW];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_wdata_q [$];
    logic [31:0] exp_saddr_q [$];
    logic [31:0] exp_sdata_q [$];
    logic        armed;
    logic        run_q;

    initial begin
        done_o   = 1'b0;
        steps_o  = 0;
        errors_o = 0;
        armed    = 1'b0;
        run_q    = 1'b0;
    end

    always @(posedge clk_i) begin
        if (imem_wr_en_i) begin
            prog_mem[imem_wr_addr_i[`CPU_IMEM_AW+1:2]] = imem_wr_data_i;
        end
    end

    // runs the program architecturally until it reaches the jump to itself
    function automatic int run_model();
        logic [31:0] regs [32];
        logic [31:0] dmem [2**`CPU_DMEM_AW];
        logic [31:0] pc, instr, a, b, res, addr, next_pc, sext, jtarget;
        logic [4:0]  dst;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < 2**`CPU_DMEM_AW; i++) dmem[i] = '0;
        pc    = '0;
        steps = 0;
        while (steps < 1000) begin
            instr   = prog_mem[pc[`CPU_IMEM_AW+1:2]];
            next_pc = pc + 32'd4;
            jtarget = {next_pc[31:28], instr[25:0], 2'b00};
            if (instr[31:26] == OP_J && jtarget == pc) break;
            steps++;
            a    = regs[instr[25:21]];
            b    = regs[instr[20:16]];
            sext = {{16{instr[15]}}, instr[15:0]};
            addr = a + sext;
            dst  = instr[20:16];
            wr   = 1'b0;
            res  = '0;
            case (opcode_e'(instr[31:26]))
                OP_RTYPE: begin
                    dst = instr[15:11];
                    wr  = 1'b1;
                    case (funct_e'(instr[5:0]))
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << instr[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    res = addr;
                    wr  = 1'b1;
                end
                OP_ORI: begin
                    res = a | {16'b0, instr[15:0]};
                    wr  = 1'b1;
                end
                OP_LW: begin
                    res = dmem[addr[`CPU_DMEM_AW+1:2]];
                    wr  = 1'b1;
                end
                OP_SW: begin
                    dmem[addr[`CPU_DMEM_AW+1:2]] = b;
                    exp_saddr_q.push_back(addr);
                    exp_sdata_q.push_back(b);
                end
                OP_BEQ: if (a == b) next_pc = next_pc + {sext[29:0], 2'b00};
                OP_J:   next_pc = jtarget;
                default: ;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_rd_q.push_back(dst);
                exp_wdata_q.push_back(res);
            end
            pc = next_pc;
        end
        return steps;
    endfunction

    task automatic check_retire();
        if (!armed || exp_rd_q.size() == 0) begin
            $display("unexpected register write to r%0d while nothing is expected", retire_rd_i);
            errors_o++;
        end else begin
            if (retire_rd_i !== exp_rd_q[0]) begin
                $display("** Error: retire_rd_o expected 0x%h got 0x%h", exp_rd_q[0], retire_rd_i);
                errors_o++;
            end
            if (retire_data_i !== exp_wdata_q[0]) begin
                $display("** Error: retire_data_o expected 0x%h got 0x%h",
                         exp_wdata_q[0], retire_data_i);
                errors_o++;
            end
            void'(exp_rd_q.pop_front());
            void'(exp_wdata_q.pop_front());
        end
    endtask

    task automatic check_store();
        if (!armed || exp_saddr_q.size() == 0) begin
            $display("unexpected store to 0x%h while nothing is expected", store_addr_i);
            errors_o++;
        end else begin
            if (store_addr_i !== exp_saddr_q[0]) begin
                $display("** Error: store_addr_o expected 0x%h got 0x%h",
                         exp_saddr_q[0], store_addr_i);
                errors_o++;
            end
            if (store_data_i !== exp_sdata_q[0]) begin
                $display("** Error: store_data_o expected 0x%h got 0x%h",
                         exp_sdata_q[0], store_data_i);
                errors_o++;
            end
            void'(exp_saddr_q.pop_front());
            void'(exp_sdata_q.pop_front());
        end
    endtask

    // outputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            armed  = 1'b0;
            run_q  = 1'b0;
            done_o = 1'b0;
        end else begin
            if (run_i && !run_q) begin
                exp_rd_q.delete();
                exp_wdata_q.delete();
                exp_saddr_q.delete();
                exp_sdata_q.delete();
                steps_o = run_model();
                armed   = 1'b1;
            end
            if (!run_i) armed = 1'b0;
            run_q = run_i;
            if (retire_valid_i) check_retire();
            if (store_valid_i) check_store();
            done_o = armed && exp_rd_q.size() == 0 && exp_saddr_q.size() == 0;
        end
    end

endmodule

// ==== dv/cpu_tb.sv ====
// every program ends in a jump to itself; registers are written before any test reads them
`timescale 1ns/1ps

module cpu_tb import isa_pkg::*;;

    logic        clk, arst_n, run, imem_wr_en;
    logic [31:0] imem_wr_addr, imem_wr_data;
    logic        retire_valid, store_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data, store_addr, store_data;
    logic        done;
    int          steps, errors;
    instr_t      prog_q [$];
    integer      seed;
    int          tests_run, tests_failed, wait_cycles;
    logic        waiting;

    cpu_top dut_i (
        .clk_i (clk), .arst_n_i (arst_n), .run_i (run),
        .imem_wr_en_i (imem_wr_en), .imem_wr_addr_i (imem_wr_addr),
        .imem_wr_data_i (imem_wr_data),
        .retire_valid_o (retire_valid), .retire_rd_o (retire_rd),
        .retire_data_o (retire_data), .store_valid_o (store_valid),
        .store_addr_o (store_addr), .store_data_o (store_data)
    );

    cpu_monitor mon_i (
        .clk_i (clk), .arst_n_i (arst_n), .run_i (run),
        .imem_wr_en_i (imem_wr_en), .imem_wr_addr_i (imem_wr_addr),
        .imem_wr_data_i (imem_wr_data),
        .retire_valid_i (retire_valid), .retire_rd_i (retire_rd),
        .retire_data_i (retire_data), .store_valid_i (store_valid),
        .store_addr_i (store_addr), .store_data_i (store_data),
        .done_o (done), .steps_o (steps), .errors_o (errors)
    );

    always #50 clk = ~clk;

    // limit is 8 cycles per model instruction plus 50
    always @(posedge clk) begin
        if (waiting) begin
            wait_cycles++;
            if (wait_cycles > 8 * steps + 50) begin
                $display("test timed out after %0d cycles without draining", wait_cycles);
                $display("Result: FAILED");
                $finish;
            end
        end
    end

    function automatic instr_t rtype_word(funct_e fn, int rd, int rs, int rt, int sh);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic instr_t itype_word(opcode_e op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic instr_t jump_word(int idx);
        return {OP_J, idx[25:0]};
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #1 arst_n = 1'b0;
        run = 1'b0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
    endtask

    task automatic load_program();
        prog_q.push_back(jump_word(prog_q.size()));
        foreach (prog_q[i]) begin
            @(posedge clk);
            #1 imem_wr_en = 1'b1;
            imem_wr_addr = i * 4;
            imem_wr_data = prog_q[i];
        end
        @(posedge clk);
        #1 imem_wr_en = 1'b0;
        prog_q.delete();
    endtask

    task automatic report(string name, int errs_before);
        int n;
        n = errors - errs_before;
        tests_run++;
        if (n != 0) tests_failed++;
        $display("test %s: %s, %0d mismatches", name, (n == 0) ? "ok" : "bad", n);
    endtask

    task automatic run_program(string name);
        int errs_before;
        errs_before = errors;
        apply_reset();
        load_program();
        @(posedge clk);
        #1 run = 1'b1;
        wait_cycles = 0;
        waiting = 1'b1;
        do @(posedge clk); while (!done);
        waiting = 1'b0;
        repeat (10) @(posedge clk);  // lets a stray retire behind the last one show up
        report(name, errs_before);
    endtask

    task automatic idle_test();
        int errs_before;
        errs_before = errors;
        apply_reset();
        prog_q.push_back(itype_word(OP_ADDIU, 1, 0, 1));
        prog_q.push_back(itype_word(OP_SW, 1, 0, 0));
        load_program();
        repeat (20) @(posedge clk);  // the monitor flags any retire or store here
        report("idle", errs_before);
    endtask

    task automatic build_random();
        int r;
        for (int i = 1; i <= 8; i++) begin
            r = $random(seed);
            prog_q.push_back(itype_word(OP_ADDIU, i, 0, r));
        end
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            case (r[2:0])
                3'd0: prog_q.push_back(rtype_word(FN_ADDU, 1 + r[5:3], 1 + r[8:6], 1 + r[11:9], 0));
                3'd1: prog_q.push_back(rtype_word(FN_SUBU, 1 + r[5:3], 1 + r[8:6], 1 + r[11:9], 0));
                3'd2: prog_q.push_back(rtype_word(FN_AND, 1 + r[5:3], 1 + r[8:6], 1 + r[11:9], 0));
                3'd3: prog_q.push_back(rtype_word(FN_OR, 1 + r[5:3], 1 + r[8:6], 1 + r[11:9], 0));
                3'd4: prog_q.push_back(rtype_word(FN_SLT, 1 + r[5:3], 1 + r[8:6], 1 + r[11:9], 0));
                3'd5: prog_q.push_back(rtype_word(FN_SLL, 1 + r[5:3], 0, 1 + r[11:9], r[16:12]));
                3'd6: prog_q.push_back(itype_word(OP_ADDIU, 1 + r[5:3], 1 + r[8:6], r[31:16]));
                default: prog_q.push_back(itype_word(OP_ORI, 1 + r[5:3], 1 + r[8:6], r[31:16]));
            endcase
        end
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        run = 1'b0;
        imem_wr_en = 1'b0;
        imem_wr_addr = '0;
        imem_wr_data = '0;
        waiting = 1'b0;
        wait_cycles = 0;
        tests_run = 0;
        tests_failed = 0;
        seed = 32'h6943_e774;

        idle_test();

        prog_q = '{itype_word(OP_ADDIU, 1, 0, 5), itype_word(OP_ADDIU, 2, 1, -3),
                   rtype_word(FN_ADDU, 3, 1, 2, 0), rtype_word(FN_SUBU, 4, 3, 1, 0),
                   rtype_word(FN_SLL, 5, 0, 4, 4), rtype_word(FN_SLT, 6, 4, 5, 0),
                   rtype_word(FN_SLT, 7, 5, 2, 0), itype_word(OP_ORI, 8, 7, 16'hf0f0),
                   rtype_word(FN_AND, 9, 8, 5, 0), rtype_word(FN_OR, 10, 9, 3, 0),
                   itype_word(OP_ADDIU, 11, 0, -1), rtype_word(FN_SLT, 12, 11, 1, 0)};
        run_program("alu_forward");

        prog_q = '{itype_word(OP_ADDIU, 1, 0, 16'h40), itype_word(OP_ADDIU, 2, 0, 16'h1234),
                   itype_word(OP_SW, 2, 1, 0), itype_word(OP_LW, 3, 1, 0),
                   rtype_word(FN_ADDU, 4, 3, 3, 0), itype_word(OP_SW, 4, 1, 4),
                   itype_word(OP_LW, 5, 1, 4), rtype_word(FN_SUBU, 6, 5, 2, 0)};
        run_program("load_use");

        prog_q = '{itype_word(OP_ADDIU, 1, 0, 7), itype_word(OP_ADDIU, 2, 0, 7),
                   itype_word(OP_BEQ, 2, 1, 2), itype_word(OP_ADDIU, 3, 0, 1),
                   itype_word(OP_ADDIU, 4, 0, 2), itype_word(OP_ADDIU, 5, 0, 3),
                   itype_word(OP_BEQ, 5, 1, 1), itype_word(OP_ADDIU, 6, 0, 4),
                   jump_word(10), itype_word(OP_ADDIU, 7, 0, 5),
                   itype_word(OP_ADDIU, 8, 0, 6), itype_word(OP_BEQ, 0, 0, 1),
                   itype_word(OP_ADDIU, 9, 0, 9)};
        run_program("branch_jump");

        prog_q = '{itype_word(OP_ADDIU, 0, 0, 16'h55), itype_word(OP_ADDIU, 1, 0, 16'h11),
                   rtype_word(FN_OR, 0, 1, 1, 0), rtype_word(FN_ADDU, 2, 0, 1, 0),
                   itype_word(OP_ORI, 3, 0, 16'h22), itype_word(OP_SW, 0, 0, 0),
                   itype_word(OP_LW, 4, 0, 0), rtype_word(FN_ADDU, 5, 4, 1, 0)};
        run_program("reg_zero");

        build_random();
        run_program("random_alu");

        $display("%0d tests run, %0d failed, %0d mismatches, %0d assertion failures in total",
                 tests_run, tests_failed, errors, dut_i.issue_i.chk_i.fails);
        if (tests_failed == 0 && errors == 0 && dut_i.issue_i.chk_i.fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/pipe_if.sv
source/fetch_stage.sv
source/issue_stage.sv
source/exec_stage.sv
source/mem_wb_stage.sv
source/cpu_top.sv
dv/cpu_chk.sv
dv/cpu_monitor.sv
dv/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpu_tb -o cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/cpu_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
